//--- rtl/lsu_settings.svh
/* load/store stage sizing */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width
`define LSU_XLEN 32

// data memory depth in words
`define LSU_DMEM_WORDS 1024

// request buffer entries, equal to the execute stage's starting credits
`define LSU_REQ_DEPTH 2

// write-back credits held after reset
`define LSU_WB_CREDITS 2

`endif

//--- rtl/mem_access_pkg.sv
/* memory access types */
`default_nettype none
`include "lsu_settings.svh"

package mem_access_pkg;

    // one data or address word
    typedef logic [`LSU_XLEN-1:0] word_t;

    // one strobe bit per byte lane
    typedef logic [`LSU_XLEN/8-1:0] strobe_t;

    // load encodings
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,
        LOAD_LB   = 3'd1,
        LOAD_LH   = 3'd2,
        LOAD_LW   = 3'd3,
        LOAD_LBU  = 3'd4,
        LOAD_LHU  = 3'd5
    } load_type_t;

    // store encodings
    typedef enum logic [1:0] {
        STORE_NONE = 2'd0,
        STORE_SB   = 2'd1,
        STORE_SH   = 2'd2,
        STORE_SW   = 2'd3
    } store_type_t;

endpackage

`default_nettype wire

//--- rtl/writeback_pkg.sv
/* write-back side types */
`default_nettype none

package writeback_pkg;

    // destination register index
    typedef logic [4:0] reg_idx_t;

    // csr operation, carried through untouched
    typedef logic [2:0] csr_type_t;

    // load/store control states
    typedef enum logic [1:0] {
        LSU_IDLE   = 2'd0,
        LSU_ACCESS = 2'd1,
        LSU_RESULT = 2'd2
    } lsu_state_t;

endpackage

`default_nettype wire

//--- rtl/lsu_req_buffer.sv
/* execute request buffer */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_req_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push_i,
    input  mem_access_pkg::word_t       alu_result_i,
    input  mem_access_pkg::word_t       wdata_i,
    input  mem_access_pkg::load_type_t  load_type_i,
    input  mem_access_pkg::store_type_t store_type_i,
    input  logic                        wd_i,
    input  writeback_pkg::reg_idx_t     wreg_i,
    input  mem_access_pkg::word_t       csr_wdata_i,
    input  writeback_pkg::csr_type_t    csr_type_i,
    input  logic                        pop_i,
    output logic                        head_valid_o,
    output mem_access_pkg::word_t       head_alu_result_o,
    output mem_access_pkg::word_t       head_wdata_o,
    output mem_access_pkg::load_type_t  head_load_type_o,
    output mem_access_pkg::store_type_t head_store_type_o,
    output logic                        head_wd_o,
    output writeback_pkg::reg_idx_t     head_wreg_o,
    output mem_access_pkg::word_t       head_csr_wdata_o,
    output writeback_pkg::csr_type_t    head_csr_type_o,
    output logic                        credit_o
);
    import mem_access_pkg::*;
    import writeback_pkg::*;

    localparam int DEPTH = `LSU_REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage, one array per field
    word_t       alu_result_q [DEPTH];
    word_t       wdata_q      [DEPTH];
    load_type_t  load_type_q  [DEPTH];
    store_type_t store_type_q [DEPTH];
    logic        wd_q         [DEPTH];
    reg_idx_t    wreg_q       [DEPTH];
    word_t       csr_wdata_q  [DEPTH];
    csr_type_t   csr_type_q   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap at the last entry
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // no full check, the sender's credits guarantee a free slot
    always_ff @(posedge clk) begin
        if (push_i) begin
            alu_result_q[wr_ptr] <= alu_result_i;
            wdata_q[wr_ptr]      <= wdata_i;
            load_type_q[wr_ptr]  <= load_type_i;
            store_type_q[wr_ptr] <= store_type_i;
            wd_q[wr_ptr]         <= wd_i;
            wreg_q[wr_ptr]       <= wreg_i;
            csr_wdata_q[wr_ptr]  <= csr_wdata_i;
            csr_type_q[wr_ptr]   <= csr_type_i;
        end
    end

    assign head_valid_o      = (count != '0);
    assign head_alu_result_o = alu_result_q[rd_ptr];
    assign head_wdata_o      = wdata_q[rd_ptr];
    assign head_load_type_o  = load_type_q[rd_ptr];
    assign head_store_type_o = store_type_q[rd_ptr];
    assign head_wd_o         = wd_q[rd_ptr];
    assign head_wreg_o       = wreg_q[rd_ptr];
    assign head_csr_wdata_o  = csr_wdata_q[rd_ptr];
    assign head_csr_type_o   = csr_type_q[rd_ptr];

    // each released entry hands one credit back to execute
    assign credit_o = pop_i;

endmodule

`default_nettype wire

//--- rtl/lsu_byte_lanes.sv
/* load/store byte lanes */
`timescale 1ns/1ps
`default_nettype none

module lsu_byte_lanes (
    input  logic [1:0]                  addr_lo_i,
    input  mem_access_pkg::store_type_t store_type_i,
    input  mem_access_pkg::word_t       store_data_i,
    input  mem_access_pkg::load_type_t  load_type_i,
    input  logic [1:0]                  load_addr_lo_i,
    input  mem_access_pkg::word_t       raw_rdata_i,
    output mem_access_pkg::strobe_t     wstrb_o,
    output mem_access_pkg::word_t       wdata_o,
    output mem_access_pkg::word_t       rdata_o
);
    import mem_access_pkg::*;

    word_t shifted;

    // store side, data copied into every lane and strobe picks the target
    always_comb begin
        case (store_type_i)
            STORE_SB: begin
                wdata_o = {4{store_data_i[7:0]}};
                wstrb_o = 4'b0001 << addr_lo_i;
            end
            STORE_SH: begin
                wdata_o = {2{store_data_i[15:0]}};
                wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            STORE_SW: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b1111;
            end
            default: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b0000;
            end
        endcase
    end

    // addressed lane moved down to bit 0
    assign shifted = raw_rdata_i >> {load_addr_lo_i, 3'b000};

    always_comb begin
        case (load_type_i)
            LOAD_LB: begin
                rdata_o = {{24{shifted[7]}}, shifted[7:0]};
            end
            LOAD_LH: begin
                rdata_o = {{16{shifted[15]}}, shifted[15:0]};
            end
            LOAD_LBU: begin
                rdata_o = {24'h000000, shifted[7:0]};
            end
            LOAD_LHU: begin
                rdata_o = {16'h0000, shifted[15:0]};
            end
            // full word, or nothing to extract
            default: begin
                rdata_o = raw_rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/data_sram.sv
/* data memory */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module data_sram (
    input  logic                    clk,
    input  logic                    wen_i,
    input  logic                    ren_i,
    input  mem_access_pkg::word_t   addr_i,
    input  mem_access_pkg::strobe_t wstrb_i,
    input  mem_access_pkg::word_t   wdata_i,
    output mem_access_pkg::word_t   rdata_o
);
    import mem_access_pkg::*;

    localparam int WORDS = `LSU_DMEM_WORDS;
    localparam int AW    = $clog2(WORDS);
    localparam int LANES = `LSU_XLEN / 8;

    word_t         mem [WORDS];
    logic [AW-1:0] word_addr;

    // byte address to word index
    assign word_addr = addr_i[AW+1:2];

    always_ff @(posedge clk) begin
        if (wen_i) begin
            for (int b = 0; b < LANES; b++) begin
                if (wstrb_i[b]) begin
                    mem[word_addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
        // registered read, data one cycle later
        if (ren_i) begin
            rdata_o <= mem[word_addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_ctrl.sv
/* load/store control */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module lsu_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        head_valid_i,
    input  mem_access_pkg::word_t       head_alu_result_i,
    input  mem_access_pkg::word_t       head_wdata_i,
    input  mem_access_pkg::load_type_t  head_load_type_i,
    input  mem_access_pkg::store_type_t head_store_type_i,
    input  logic                        head_wd_i,
    input  writeback_pkg::reg_idx_t     head_wreg_i,
    input  mem_access_pkg::word_t       head_csr_wdata_i,
    input  writeback_pkg::csr_type_t    head_csr_type_i,
    output logic                        pop_o,
    output logic                        mem_wen_o,
    output logic                        mem_ren_o,
    output mem_access_pkg::word_t       mem_addr_o,
    output mem_access_pkg::store_type_t mem_store_type_o,
    output mem_access_pkg::word_t       mem_store_data_o,
    output mem_access_pkg::load_type_t  hold_load_type_o,
    output logic [1:0]                  hold_addr_lo_o,
    input  mem_access_pkg::word_t       rdata_i,
    input  logic                        wb_credit_i,
    output logic                        wb_valid_o,
    output logic                        wb_wd_o,
    output writeback_pkg::reg_idx_t     wb_wreg_o,
    output mem_access_pkg::word_t       wb_wdata_o,
    output mem_access_pkg::word_t       wb_csr_wdata_o,
    output writeback_pkg::csr_type_t    wb_csr_type_o,
    output logic                        wb_memory_inst_o
);
    import mem_access_pkg::*;
    import writeback_pkg::*;

    localparam int                CRED_W    = $clog2(`LSU_WB_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_INIT = CRED_W'(`LSU_WB_CREDITS);

    lsu_state_t        state;
    lsu_state_t        state_nxt;
    logic [CRED_W-1:0] wb_credits;
    logic              take;

    // request being served
    word_t       hold_alu_result;
    word_t       hold_wdata;
    load_type_t  hold_load_type;
    store_type_t hold_store_type;
    logic        hold_wd;
    reg_idx_t    hold_wreg;
    word_t       hold_csr_wdata;
    csr_type_t   hold_csr_type;

    // start only with a credit in hand for the record
    assign take  = (state == LSU_IDLE) && head_valid_i && (wb_credits != '0);
    assign pop_o = take;

    always_comb begin
        state_nxt = state;
        case (state)
            LSU_IDLE: begin
                if (take) begin
                    state_nxt = LSU_ACCESS;
                end
            end
            LSU_ACCESS: begin
                state_nxt = LSU_RESULT;
            end
            LSU_RESULT: begin
                state_nxt = LSU_IDLE;
            end
            default: begin
                state_nxt = LSU_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= LSU_IDLE;
            wb_credits <= CRED_INIT;
        end else begin
            state <= state_nxt;
            // spend and return may land together
            case ({wb_valid_o, wb_credit_i})
                2'b10:   wb_credits <= wb_credits - 1'b1;
                2'b01:   wb_credits <= wb_credits + 1'b1;
                default: wb_credits <= wb_credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hold_alu_result <= head_alu_result_i;
            hold_wdata      <= head_wdata_i;
            hold_load_type  <= head_load_type_i;
            hold_store_type <= head_store_type_i;
            hold_wd         <= head_wd_i;
            hold_wreg       <= head_wreg_i;
            hold_csr_wdata  <= head_csr_wdata_i;
            hold_csr_type   <= head_csr_type_i;
        end
    end

    // memory is touched only in the access cycle
    assign mem_wen_o        = (state == LSU_ACCESS) && (hold_store_type != STORE_NONE);
    assign mem_ren_o        = (state == LSU_ACCESS) && (hold_load_type != LOAD_NONE);
    assign mem_addr_o       = hold_alu_result;
    assign mem_store_type_o = hold_store_type;
    assign mem_store_data_o = hold_wdata;
    assign hold_load_type_o = hold_load_type;
    assign hold_addr_lo_o   = hold_alu_result[1:0];

    // record, read data arrives in the result cycle
    assign wb_valid_o       = (state == LSU_RESULT);
    assign wb_wd_o          = hold_wd;
    assign wb_wreg_o        = hold_wreg;
    assign wb_wdata_o       = (hold_load_type != LOAD_NONE) ? rdata_i : hold_alu_result;
    assign wb_csr_wdata_o   = hold_csr_wdata;
    assign wb_csr_type_o    = hold_csr_type;
    assign wb_memory_inst_o = (hold_load_type != LOAD_NONE) || (hold_store_type != STORE_NONE);

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
/* load/store stage top */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid_i,
    input  mem_access_pkg::word_t       req_alu_result_i,
    input  mem_access_pkg::word_t       req_wdata_i,
    input  mem_access_pkg::load_type_t  req_load_type_i,
    input  mem_access_pkg::store_type_t req_store_type_i,
    input  logic                        req_wd_i,
    input  writeback_pkg::reg_idx_t     req_wreg_i,
    input  mem_access_pkg::word_t       req_csr_wdata_i,
    input  writeback_pkg::csr_type_t    req_csr_type_i,
    output logic                        req_credit_o,
    input  logic                        wb_credit_i,
    output logic                        wb_valid_o,
    output logic                        wb_wd_o,
    output writeback_pkg::reg_idx_t     wb_wreg_o,
    output mem_access_pkg::word_t       wb_wdata_o,
    output mem_access_pkg::word_t       wb_csr_wdata_o,
    output writeback_pkg::csr_type_t    wb_csr_type_o,
    output logic                        wb_memory_inst_o
);
    import mem_access_pkg::*;
    import writeback_pkg::*;

    // buffer head
    logic        head_valid;
    word_t       head_alu_result;
    word_t       head_wdata;
    load_type_t  head_load_type;
    store_type_t head_store_type;
    logic        head_wd;
    reg_idx_t    head_wreg;
    word_t       head_csr_wdata;
    csr_type_t   head_csr_type;
    logic        pop;

    // memory side
    logic        mem_wen;
    logic        mem_ren;
    word_t       mem_addr;
    store_type_t mem_store_type;
    word_t       mem_store_data;
    load_type_t  hold_load_type;
    logic [1:0]  hold_addr_lo;
    strobe_t     mem_wstrb;
    word_t       mem_wdata;
    word_t       mem_rdata_raw;
    word_t       mem_rdata;

    lsu_req_buffer u_req_buffer (
        .clk               (clk),
        .rst               (rst),
        .push_i            (req_valid_i),
        .alu_result_i      (req_alu_result_i),
        .wdata_i           (req_wdata_i),
        .load_type_i       (req_load_type_i),
        .store_type_i      (req_store_type_i),
        .wd_i              (req_wd_i),
        .wreg_i            (req_wreg_i),
        .csr_wdata_i       (req_csr_wdata_i),
        .csr_type_i        (req_csr_type_i),
        .pop_i             (pop),
        .head_valid_o      (head_valid),
        .head_alu_result_o (head_alu_result),
        .head_wdata_o      (head_wdata),
        .head_load_type_o  (head_load_type),
        .head_store_type_o (head_store_type),
        .head_wd_o         (head_wd),
        .head_wreg_o       (head_wreg),
        .head_csr_wdata_o  (head_csr_wdata),
        .head_csr_type_o   (head_csr_type),
        .credit_o          (req_credit_o)
    );

    lsu_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .head_valid_i      (head_valid),
        .head_alu_result_i (head_alu_result),
        .head_wdata_i      (head_wdata),
        .head_load_type_i  (head_load_type),
        .head_store_type_i (head_store_type),
        .head_wd_i         (head_wd),
        .head_wreg_i       (head_wreg),
        .head_csr_wdata_i  (head_csr_wdata),
        .head_csr_type_i   (head_csr_type),
        .pop_o             (pop),
        .mem_wen_o         (mem_wen),
        .mem_ren_o         (mem_ren),
        .mem_addr_o        (mem_addr),
        .mem_store_type_o  (mem_store_type),
        .mem_store_data_o  (mem_store_data),
        .hold_load_type_o  (hold_load_type),
        .hold_addr_lo_o    (hold_addr_lo),
        .rdata_i           (mem_rdata),
        .wb_credit_i       (wb_credit_i),
        .wb_valid_o        (wb_valid_o),
        .wb_wd_o           (wb_wd_o),
        .wb_wreg_o         (wb_wreg_o),
        .wb_wdata_o        (wb_wdata_o),
        .wb_csr_wdata_o    (wb_csr_wdata_o),
        .wb_csr_type_o     (wb_csr_type_o),
        .wb_memory_inst_o  (wb_memory_inst_o)
    );

    lsu_byte_lanes u_lanes (
        .addr_lo_i      (mem_addr[1:0]),
        .store_type_i   (mem_store_type),
        .store_data_i   (mem_store_data),
        .load_type_i    (hold_load_type),
        .load_addr_lo_i (hold_addr_lo),
        .raw_rdata_i    (mem_rdata_raw),
        .wstrb_o        (mem_wstrb),
        .wdata_o        (mem_wdata),
        .rdata_o        (mem_rdata)
    );

    data_sram u_dmem (
        .clk     (clk),
        .wen_i   (mem_wen),
        .ren_i   (mem_ren),
        .addr_i  (mem_addr),
        .wstrb_i (mem_wstrb),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata_raw)
    );

endmodule

`default_nettype wire

//--- testbench/tb_lsu_top.sv
/* load/store stage testbench */
`timescale 1ns/1ps
`default_nettype none
`include "lsu_settings.svh"

module tb_lsu_top;
    import mem_access_pkg::*;
    import writeback_pkg::*;

    localparam int REQ_DEPTH    = `LSU_REQ_DEPTH;
    localparam int WB_CREDITS   = `LSU_WB_CREDITS;
    localparam int NUM_REQ      = 400;
    localparam int REGION_WORDS = 16;
    localparam int REGION_BYTES = REGION_WORDS * 4;
    localparam int BASE_ADDR    = 32'h0000_0200;
    // about 8 cycles per request at worst with credit holds plus reset and drain
    localparam int CYCLE_LIMIT  = NUM_REQ * 8 + 800;

    // record kinds where loads follow the order lb lh lw lbu lhu
    localparam logic [2:0] KIND_STORE = 3'd0;
    localparam logic [2:0] KIND_ALU   = 3'd6;

    typedef struct packed {
        logic [2:0] kind;
        logic       wd;
        reg_idx_t   wreg;
        word_t      wdata;
        word_t      csr_wdata;
        csr_type_t  csr_type;
        logic       mem_inst;
    } exp_rec_t;

    logic        clk;
    logic        rst;
    logic        req_valid_i;
    word_t       req_alu_result_i;
    word_t       req_wdata_i;
    load_type_t  req_load_type_i;
    store_type_t req_store_type_i;
    logic        req_wd_i;
    reg_idx_t    req_wreg_i;
    word_t       req_csr_wdata_i;
    csr_type_t   req_csr_type_i;
    logic        req_credit_o;
    logic        wb_credit_i;
    logic        wb_valid_o;
    logic        wb_wd_o;
    reg_idx_t    wb_wreg_o;
    word_t       wb_wdata_o;
    word_t       wb_csr_wdata_o;
    csr_type_t   wb_csr_type_o;
    logic        wb_memory_inst_o;

    int          seed;
    int          cycle;
    int          sent;
    int          credits_back;
    int          received;
    int          wb_returned;
    logic        prev_wb_valid;
    logic        done;
    logic [7:0]  ref_mem [REGION_BYTES];
    exp_rec_t    exp_q [$];
    int          credit_due [$];

    lsu_top u_lsu_top (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid_i),
        .req_alu_result_i (req_alu_result_i),
        .req_wdata_i      (req_wdata_i),
        .req_load_type_i  (req_load_type_i),
        .req_store_type_i (req_store_type_i),
        .req_wd_i         (req_wd_i),
        .req_wreg_i       (req_wreg_i),
        .req_csr_wdata_i  (req_csr_wdata_i),
        .req_csr_type_i   (req_csr_type_i),
        .req_credit_o     (req_credit_o),
        .wb_credit_i      (wb_credit_i),
        .wb_valid_o       (wb_valid_o),
        .wb_wd_o          (wb_wd_o),
        .wb_wreg_o        (wb_wreg_o),
        .wb_wdata_o       (wb_wdata_o),
        .wb_csr_wdata_o   (wb_csr_wdata_o),
        .wb_csr_type_o    (wb_csr_type_o),
        .wb_memory_inst_o (wb_memory_inst_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // credits the execute model still holds
    function automatic int exec_credits();
        return REQ_DEPTH + credits_back - sent;
    endfunction

    function automatic string kind_name(input logic [2:0] kind);
        string name;
        case (kind)
            3'd0:    name = "store";
            3'd1:    name = "load lb";
            3'd2:    name = "load lh";
            3'd3:    name = "load lw";
            3'd4:    name = "load lbu";
            3'd5:    name = "load lhu";
            default: name = "alu passthrough";
        endcase
        return name;
    endfunction

    // little-endian byte view of the region with the extension the load asks for
    function automatic word_t ref_load(input load_type_t ltype, input logic [5:0] off);
        logic [15:0] half;
        word_t       result;
        half = {ref_mem[off + 6'd1], ref_mem[off]};
        case (ltype)
            LOAD_LB:  result = {{24{ref_mem[off][7]}}, ref_mem[off]};
            LOAD_LBU: result = {24'h000000, ref_mem[off]};
            LOAD_LH:  result = {{16{half[15]}}, half};
            LOAD_LHU: result = {16'h0000, half};
            default:  result = {ref_mem[off + 6'd3], ref_mem[off + 6'd2], half};
        endcase
        return result;
    endfunction

    task automatic ref_store(input store_type_t stype, input logic [5:0] off, input word_t data);
        int nbytes;
        nbytes = (stype == STORE_SB) ? 1 : (stype == STORE_SH) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            ref_mem[off + 6'(b)] = data[b*8 +: 8];
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_quiet(input string when);
        assert (wb_valid_o === 1'b0 && req_credit_o === 1'b0)
            else fail_now({"wb_valid_o or req_credit_o high ", when});
    endtask

    // word stores fill the region first and a random mix follows
    task automatic send_request(input int idx);
        exp_rec_t    rec;
        word_t       data;
        word_t       addr;
        logic [5:0]  off;
        load_type_t  ltype;
        store_type_t stype;
        int          pick;
        int          lsel;
        int          size;
        int          word_idx;
        rec.wd        = 1'(rand_below(2));
        rec.wreg      = 5'(rand_below(32));
        rec.csr_wdata = $random(seed);
        rec.csr_type  = 3'(rand_below(8));
        data          = $random(seed);
        ltype         = LOAD_NONE;
        stype         = STORE_NONE;
        pick          = (idx < REGION_WORDS) ? 0 : rand_below(8);
        word_idx      = (idx < REGION_WORDS) ? idx : rand_below(REGION_WORDS);
        if (pick < 3) begin
            lsel  = (idx < REGION_WORDS) ? 2 : rand_below(3);
            stype = (lsel == 0) ? STORE_SB : (lsel == 1) ? STORE_SH : STORE_SW;
            size  = (lsel == 0) ? 1 : (lsel == 1) ? 2 : 4;
            off   = 6'(word_idx * 4 + rand_below(4 / size) * size);
            addr  = word_t'(BASE_ADDR) + word_t'(off);
            ref_store(stype, off, data);
            rec.kind     = KIND_STORE;
            rec.wdata    = addr;
            rec.mem_inst = 1'b1;
        end else if (pick < 6) begin
            lsel = rand_below(5);
            case (lsel)
                0:       ltype = LOAD_LB;
                1:       ltype = LOAD_LH;
                2:       ltype = LOAD_LW;
                3:       ltype = LOAD_LBU;
                default: ltype = LOAD_LHU;
            endcase
            size = (lsel == 0 || lsel == 3) ? 1 : (lsel == 2) ? 4 : 2;
            off  = 6'(word_idx * 4 + rand_below(4 / size) * size);
            addr = word_t'(BASE_ADDR) + word_t'(off);
            rec.kind     = 3'(1 + lsel);
            rec.wdata    = ref_load(ltype, off);
            rec.mem_inst = 1'b1;
        end else begin
            addr         = $random(seed);
            rec.kind     = KIND_ALU;
            rec.wdata    = addr;
            rec.mem_inst = 1'b0;
        end
        req_valid_i      <= 1'b1;
        req_alu_result_i <= addr;
        req_wdata_i      <= data;
        req_load_type_i  <= ltype;
        req_store_type_i <= stype;
        req_wd_i         <= rec.wd;
        req_wreg_i       <= rec.wreg;
        req_csr_wdata_i  <= rec.csr_wdata;
        req_csr_type_i   <= rec.csr_type;
        exp_q.push_back(rec);
    endtask

    task automatic check_record();
        exp_rec_t rec;
        string    test;
        assert (exp_q.size() > 0) else fail_now("write-back record with no request outstanding");
        rec  = exp_q.pop_front();
        test = kind_name(rec.kind);
        check_field(test, "wb_wd_o", 32'(rec.wd), 32'(wb_wd_o));
        check_field(test, "wb_wreg_o", 32'(rec.wreg), 32'(wb_wreg_o));
        check_field(test, "wb_wdata_o", rec.wdata, wb_wdata_o);
        check_field(test, "wb_csr_wdata_o", rec.csr_wdata, wb_csr_wdata_o);
        check_field(test, "wb_csr_type_o", 32'(rec.csr_type), 32'(wb_csr_type_o));
        check_field(test, "wb_memory_inst_o", 32'(rec.mem_inst), 32'(wb_memory_inst_o));
    endtask

    // sampled at the falling edge away from the driving edge
    task automatic monitor_cycle();
        int captured;
        // a pulse driven this cycle is not yet seen by the DUT
        captured = wb_returned - (wb_credit_i ? 1 : 0);
        if (req_credit_o) begin
            credits_back++;
        end
        assert (exec_credits() >= 0 && exec_credits() <= REQ_DEPTH)
            else fail_now("execute credit count went out of range");
        assert (!(wb_valid_o && prev_wb_valid))
            else fail_now("wb_valid_o stayed high for two cycles in a row");
        if (wb_valid_o) begin
            received++;
            assert (received <= WB_CREDITS + captured)
                else fail_now("more write-back records than returned credits");
            check_record();
            // now and then the write-back side holds its credit back
            if (rand_below(16) == 0) begin
                credit_due.push_back(cycle + 20);
            end else begin
                credit_due.push_back(cycle + rand_below(5));
            end
        end
        prev_wb_valid = wb_valid_o;
    endtask

    initial begin
        seed             = 95;
        cycle            = 0;
        sent             = 0;
        credits_back     = 0;
        received         = 0;
        wb_returned      = 0;
        prev_wb_valid    = 1'b0;
        done             = 1'b0;
        rst              = 1'b1;
        req_valid_i      = 1'b0;
        req_alu_result_i = '0;
        req_wdata_i      = '0;
        req_load_type_i  = LOAD_NONE;
        req_store_type_i = STORE_NONE;
        req_wd_i         = 1'b0;
        req_wreg_i       = '0;
        req_csr_wdata_i  = '0;
        req_csr_type_i   = '0;
        wb_credit_i      = 1'b0;

        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            if (i == 2) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            check_quiet("during or right after reset");
        end

        while (!done) begin
            @(posedge clk);
            if (sent < NUM_REQ && exec_credits() > 0 && rand_below(4) != 0) begin
                send_request(sent);
                sent++;
            end else begin
                req_valid_i <= 1'b0;
            end
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                wb_credit_i <= 1'b1;
                wb_returned++;
            end else begin
                wb_credit_i <= 1'b0;
            end
            @(negedge clk);
            cycle++;
            monitor_cycle();
            if (cycle >= CYCLE_LIMIT) begin
                fail_now($sformatf("timeout, run still busy after %0d cycles", cycle));
            end
            done = (sent == NUM_REQ) && (exp_q.size() == 0) && (credit_due.size() == 0);
        end

        // let the last credit pulse land
        @(posedge clk);
        req_valid_i <= 1'b0;
        wb_credit_i <= 1'b0;
        @(negedge clk);
        check_quiet("after the last record");
        assert (exec_credits() == REQ_DEPTH)
            else fail_now("execute credits did not return to their start value");
        assert (int'(u_lsu_top.u_ctrl.wb_credits) == WB_CREDITS)
            else fail_now("write-back credits did not return to their start value");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/mem_access_pkg.sv
rtl/writeback_pkg.sv
rtl/lsu_req_buffer.sv
rtl/lsu_byte_lanes.sv
rtl/data_sram.sv
rtl/lsu_ctrl.sv
rtl/lsu_top.sv
testbench/tb_lsu_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the load/store stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_lsu_top
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_lsu_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
exit 0
